// ==== hdl/board_pkg.sv ====
// ============================================================
// ROM download and bank memory types
// ============================================================

package board_pkg;

	// byte address width of the loader stream
	localparam int DL_ADDR_W = 24;

	// lane mask encodings, bit 1 selects the high byte
	localparam logic [1:0] LANE_LO = 2'b01;
	localparam logic [1:0] LANE_HI = 2'b10;

	// one loader beat, wr rising edge marks a new byte
	typedef struct packed {
		logic                 active;
		logic                 wr;
		logic [DL_ADDR_W-1:0] addr;
		logic [7:0]           data;
	} dl_beat_t;

	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} rom_bytes_t;

	// stored word, written whole and read back per byte
	typedef union packed {
		logic [15:0] raw;
		rom_bytes_t  bytes;
	} rom_word_u;

	// per-bank write command
	// only the low bits of word_addr reach a bank
	typedef struct packed {
		logic                 en;
		logic [DL_ADDR_W-1:0] word_addr;
		logic [1:0]           lane_mask;
		rom_word_u            data;
	} rom_wr_t;

endpackage

// ==== hdl/ctrl_pkg.sv ====
// ============================================================
// keyboard, joystick and player control types
// ============================================================

package ctrl_pkg;

	// one event from the keyboard scanner
	typedef struct packed {
		logic       strobe;
		logic       pressed;
		logic [7:0] code;
	} key_event_t;

	typedef logic [7:0] joy_t;

	// joystick bit positions, bits 6 and 7 unused
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;
	localparam int JOY_BOMB  = 5;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
		logic coin;
		logic start1;
		logic start2;
	} button_state_t;

	typedef struct packed {
		logic left;
		logic right;
		logic fire;
		logic bomb;
		logic coin;
		logic start1;
		logic start2;
	} player_ctrl_t;

	// set 2 scan codes
	localparam logic [7:0] SC_UP     = 8'h75;
	localparam logic [7:0] SC_DOWN   = 8'h72;
	localparam logic [7:0] SC_LEFT   = 8'h6B;
	localparam logic [7:0] SC_RIGHT  = 8'h74;
	localparam logic [7:0] SC_ESC    = 8'h76;
	localparam logic [7:0] SC_F1     = 8'h05;
	localparam logic [7:0] SC_F2     = 8'h06;
	localparam logic [7:0] SC_SPACE  = 8'h29;
	localparam logic [7:0] SC_ALT    = 8'h11;

endpackage

// ==== hdl/rom_download_router.sv ====
`timescale 1ns/1ps

module rom_download_router #(
	parameter int BANK_COUNT = 2,
	parameter int BANK_AW    = 6
) (
	input  logic                                 clk_sys,
	input  logic                                 arst_n,
	input  board_pkg::dl_beat_t                  dl,
	output board_pkg::rom_wr_t [BANK_COUNT-1:0]  bank_wr
);
	import board_pkg::*;

	// bank index sits above the word address and the lane bit
	localparam int BANK_IDX_W = DL_ADDR_W - BANK_AW - 1;

	logic                  wr_q;
	logic                  new_byte;
	logic [BANK_IDX_W-1:0] bank_idx;
	logic [BANK_COUNT-1:0] en_d;
	logic [BANK_COUNT-1:0] en_q;
	logic [DL_ADDR_W-1:0]  word_addr_q;
	logic [1:0]            lane_mask_q;
	rom_word_u             data_q;

	assign new_byte = dl.active && dl.wr && !wr_q;
	assign bank_idx = dl.addr[DL_ADDR_W-1:BANK_AW+1];

	// one-hot bank select, no match drops the byte
	always_comb begin
		en_d = '0;
		for (int k = 0; k < BANK_COUNT; k++) begin
			en_d[k] = new_byte && (bank_idx == BANK_IDX_W'(k));
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr_q <= 1'b0;
			en_q <= '0;
		end else begin
			wr_q <= dl.wr;
			en_q <= en_d;
		end
	end

	// command payload shared by all banks
	always_ff @(posedge clk_sys) begin
		if (new_byte) begin
			word_addr_q <= DL_ADDR_W'(dl.addr[BANK_AW:1]);
			lane_mask_q <= dl.addr[0] ? LANE_HI : LANE_LO;
			data_q.raw  <= {dl.data, dl.data};
		end
	end

	always_comb begin
		for (int k = 0; k < BANK_COUNT; k++) begin
			bank_wr[k].en        = en_q[k];
			bank_wr[k].word_addr = word_addr_q;
			bank_wr[k].lane_mask = lane_mask_q;
			bank_wr[k].data      = data_q;
		end
	end

endmodule

// ==== hdl/rom_bank.sv ====
`timescale 1ns/1ps

module rom_bank #(
	parameter int BANK_AW = 6
) (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  board_pkg::rom_wr_t wr,
	input  logic [BANK_AW:0]   rd_addr,
	output logic [7:0]         rd_data
);
	import board_pkg::*;

	localparam int DEPTH = 2 ** BANK_AW;

	rom_word_u            mem [DEPTH];
	rom_word_u            rd_word_q;
	logic                 lane_q;
	logic [BANK_AW-1:0]   wr_word;

	assign wr_word = wr.word_addr[BANK_AW-1:0];

	// ============================================================
	// write side, byte lanes
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (wr.en) begin
			if (wr.lane_mask[1])
				mem[wr_word].bytes.hi <= wr.data.bytes.hi;
			if (wr.lane_mask[0])
				mem[wr_word].bytes.lo <= wr.data.bytes.lo;
		end
	end

	// ============================================================
	// read side, word and lane bit registered together
	// ============================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rd_word_q <= '0;
			lane_q    <= 1'b0;
		end else begin
			rd_word_q <= mem[rd_addr[BANK_AW:1]];
			lane_q    <= rd_addr[0];
		end
	end

	// odd byte addresses live in the high lane
	assign rd_data = lane_q ? rd_word_q.bytes.hi : rd_word_q.bytes.lo;

endmodule

// ==== hdl/key_decoder.sv ====
`timescale 1ns/1ps

module key_decoder (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  ctrl_pkg::key_event_t      key,
	output ctrl_pkg::button_state_t   buttons
);
	import ctrl_pkg::*;

	// each recognised code holds its button until the release event
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			buttons <= '0;
		end else if (key.strobe) begin
			case (key.code)
				SC_UP:
					buttons.up <= key.pressed;
				SC_DOWN:
					buttons.down <= key.pressed;
				SC_LEFT:
					buttons.left <= key.pressed;
				SC_RIGHT:
					buttons.right <= key.pressed;
				// ESC inserts a coin
				SC_ESC:
					buttons.coin <= key.pressed;
				SC_F1:
					buttons.start1 <= key.pressed;
				SC_F2:
					buttons.start2 <= key.pressed;
				SC_SPACE:
					buttons.fire1 <= key.pressed;
				SC_ALT:
					buttons.fire2 <= key.pressed;
				// unknown codes are ignored
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== hdl/control_mapper.sv ====
`timescale 1ns/1ps

module control_mapper (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  ctrl_pkg::button_state_t   buttons,
	input  ctrl_pkg::joy_t            joy0,
	input  ctrl_pkg::joy_t            joy1,
	input  logic                      rotate,
	output ctrl_pkg::player_ctrl_t    ctrl
);
	import ctrl_pkg::*;

	joy_t         joy_any;
	player_ctrl_t ctrl_d;

	// either stick may play
	assign joy_any = joy0 | joy1;

	always_comb begin
		if (rotate) begin
			// cabinet turned, vertical axis steers
			ctrl_d.left  = buttons.down | joy_any[JOY_DOWN];
			ctrl_d.right = buttons.up | joy_any[JOY_UP];
		end else begin
			ctrl_d.left  = buttons.left | joy_any[JOY_LEFT];
			ctrl_d.right = buttons.right | joy_any[JOY_RIGHT];
		end
		ctrl_d.fire   = buttons.fire1 | joy_any[JOY_FIRE];
		ctrl_d.bomb   = buttons.fire2 | joy_any[JOY_BOMB];
		ctrl_d.coin   = buttons.coin;
		ctrl_d.start1 = buttons.start1;
		ctrl_d.start2 = buttons.start2;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			ctrl <= '0;
		else
			ctrl <= ctrl_d;
	end

endmodule

// ==== hdl/core_reset_gen.sv ====
`timescale 1ns/1ps

module core_reset_gen (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      dl_active,
	input  logic                      soft_reset,
	input  ctrl_pkg::button_state_t   buttons,
	output logic                      rom_loaded,
	output logic                      core_reset
);

	logic dl_active_q;

	// rom_loaded is sticky once the first download ends
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_active_q <= 1'b0;
			rom_loaded  <= 1'b0;
			core_reset  <= 1'b1;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active_q && !dl_active)
				rom_loaded <= 1'b1;
			// coin plus start1 acts as a service reset
			core_reset <= soft_reset | (buttons.coin & buttons.start1) | ~rom_loaded;
		end
	end

endmodule

// ==== hdl/arcade_io_shell.sv ====
`timescale 1ns/1ps

module arcade_io_shell #(
	parameter int BANK_COUNT = 2,
	parameter int BANK_AW    = 6
) (
	input  logic                                clk_sys,
	input  logic                                arst_n,
	input  board_pkg::dl_beat_t                 dl,
	input  ctrl_pkg::key_event_t                key,
	input  ctrl_pkg::joy_t                      joy0,
	input  ctrl_pkg::joy_t                      joy1,
	input  logic                                rotate,
	input  logic                                soft_reset,
	input  logic [BANK_COUNT-1:0][BANK_AW:0]    rd_addr,
	output logic [BANK_COUNT-1:0][7:0]          rd_data,
	output ctrl_pkg::player_ctrl_t              ctrl,
	output logic                                rom_loaded,
	output logic                                core_reset
);
	import board_pkg::*;
	import ctrl_pkg::*;

	rom_wr_t [BANK_COUNT-1:0] bank_wr;
	button_state_t            buttons;

	// ============================================================
	// ROM download and banks
	// ============================================================
	rom_download_router #(
		.BANK_COUNT (BANK_COUNT),
		.BANK_AW    (BANK_AW)
	) i_rom_download_router (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.dl      (dl),
		.bank_wr (bank_wr)
	);

	// one bank per game CPU, main first
	for (genvar g = 0; g < BANK_COUNT; g++) begin : g_bank
		rom_bank #(
			.BANK_AW (BANK_AW)
		) i_rom_bank (
			.clk_sys (clk_sys),
			.arst_n  (arst_n),
			.wr      (bank_wr[g]),
			.rd_addr (rd_addr[g]),
			.rd_data (rd_data[g])
		);
	end

	// ============================================================
	// player controls
	// ============================================================
	key_decoder i_key_decoder (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.key     (key),
		.buttons (buttons)
	);

	control_mapper i_control_mapper (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.buttons (buttons),
		.joy0    (joy0),
		.joy1    (joy1),
		.rotate  (rotate),
		.ctrl    (ctrl)
	);

	// ============================================================
	// core reset
	// ============================================================
	core_reset_gen i_core_reset_gen (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl_active  (dl.active),
		.soft_reset (soft_reset),
		.buttons    (buttons),
		.rom_loaded (rom_loaded),
		.core_reset (core_reset)
	);

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_sys,
	output logic arst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #(HALF_PERIOD) clk_sys = ~clk_sys;
	end

	// release just after an edge so no flop sees it change at the edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#2 arst_n = 1'b1;
	end

endmodule

// ==== verif/tb_arcade_io_shell.sv ====
`timescale 1ns/1ps

module tb_arcade_io_shell;
	import board_pkg::*;
	import ctrl_pkg::*;

	localparam int BANK_COUNT     = 2;
	localparam int BANK_AW        = 6;
	localparam int BANK_BYTES     = 2 ** (BANK_AW + 1);
	localparam int ROM_BYTES      = BANK_COUNT * BANK_BYTES;
	localparam int N_STRAY        = 4;
	localparam int N_CTRL_ROWS    = 24;
	localparam int TIMEOUT_CYCLES = N_CTRL_ROWS * 3 + (ROM_BYTES + N_STRAY) * 4 + 200;

	typedef struct packed {
		key_event_t   key_ev;
		joy_t         joy0;
		joy_t         joy1;
		logic         rotate;
		player_ctrl_t expected;
	} ctrl_row_t;

	logic                               clk_sys;
	logic                               arst_n;
	dl_beat_t                           dl;
	key_event_t                         key;
	joy_t                               joy0;
	joy_t                               joy1;
	logic                               rotate;
	logic                               soft_reset;
	logic [BANK_COUNT-1:0][BANK_AW:0]   rd_addr;
	logic [BANK_COUNT-1:0][7:0]         rd_data;
	player_ctrl_t                       ctrl;
	logic                               rom_loaded;
	logic                               core_reset;

	ctrl_row_t   ctrl_rows [N_CTRL_ROWS];
	logic [7:0]  rom_image [ROM_BYTES];
	logic [31:0] lfsr_state = 32'h8bff_3e53;
	// addresses past the last bank that the router must drop
	logic [DL_ADDR_W-1:0] stray_addr [N_STRAY] = '{24'h000100, 24'h000101, 24'h000181,
		24'hFFFFFE};

	tb_clock_gen i_tb_clock_gen (
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	arcade_io_shell #(
		.BANK_COUNT (BANK_COUNT),
		.BANK_AW    (BANK_AW)
	) i_arcade_io_shell (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.dl         (dl),
		.key        (key),
		.joy0       (joy0),
		.joy1       (joy1),
		.rotate     (rotate),
		.soft_reset (soft_reset),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data),
		.ctrl       (ctrl),
		.rom_loaded (rom_loaded),
		.core_reset (core_reset)
	);

	// ============================================================
	// helpers
	// ============================================================
	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			stop_with_failure($sformatf("Fail %s got %0h expected %0h", name, actual, expected));
	endtask

	// inputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic take_random_byte(output logic [7:0] b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			b = {b[6:0], lfsr_state[0]};
		end
	endtask

	// wr high for two cycles then low for two
	task automatic send_byte(input logic [DL_ADDR_W-1:0] addr, input logic [7:0] data);
		dl.addr = addr;
		dl.data = data;
		dl.wr   = 1'b1;
		next_cycle();
		next_cycle();
		dl.wr = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	task automatic read_and_check(input int a);
		rd_addr[0] = (BANK_AW + 1)'(a);
		rd_addr[1] = (BANK_AW + 1)'(a);
		next_cycle();
		check_value($sformatf("rd_data[0] addr %0h", a), rd_data[0], rom_image[a]);
		check_value($sformatf("rd_data[1] addr %0h", a), rd_data[1], rom_image[BANK_BYTES + a]);
	endtask

	function automatic ctrl_row_t make_row(input logic strobe, input logic pressed,
		input logic [7:0] code, input joy_t j0, input joy_t j1, input logic rot,
		input player_ctrl_t expected);
		ctrl_row_t row;
		row.key_ev.strobe  = strobe;
		row.key_ev.pressed = pressed;
		row.key_ev.code    = code;
		row.joy0           = j0;
		row.joy1           = j1;
		row.rotate         = rot;
		row.expected       = expected;
		return row;
	endfunction

	// strobe, pressed, code, joy0, joy1, rotate, expected {L R F B coin s1 s2}
	task automatic load_ctrl_table();
		ctrl_rows[0]  = make_row(1, 1, SC_LEFT,  8'h00, 8'h00, 0, 7'b1000000);
		ctrl_rows[1]  = make_row(1, 0, SC_LEFT,  8'h00, 8'h00, 0, 7'b0000000);
		ctrl_rows[2]  = make_row(1, 1, SC_RIGHT, 8'h00, 8'h00, 0, 7'b0100000);
		ctrl_rows[3]  = make_row(1, 1, SC_SPACE, 8'h00, 8'h00, 0, 7'b0110000);
		ctrl_rows[4]  = make_row(1, 1, SC_ALT,   8'h00, 8'h00, 0, 7'b0111000);
		ctrl_rows[5]  = make_row(1, 0, SC_RIGHT, 8'h00, 8'h00, 0, 7'b0011000);
		ctrl_rows[6]  = make_row(1, 0, SC_SPACE, 8'h00, 8'h00, 0, 7'b0001000);
		ctrl_rows[7]  = make_row(1, 0, SC_ALT,   8'h00, 8'h00, 0, 7'b0000000);
		ctrl_rows[8]  = make_row(1, 1, SC_ESC,   8'h00, 8'h00, 0, 7'b0000100);
		// coin held while start1 goes down
		ctrl_rows[9]  = make_row(1, 1, SC_F1,    8'h00, 8'h00, 0, 7'b0000110);
		ctrl_rows[10] = make_row(1, 0, SC_ESC,   8'h00, 8'h00, 0, 7'b0000010);
		ctrl_rows[11] = make_row(1, 1, SC_F2,    8'h00, 8'h00, 0, 7'b0000011);
		// left shift is not a mapped key
		ctrl_rows[12] = make_row(1, 1, 8'h12,    8'h00, 8'h00, 0, 7'b0000011);
		ctrl_rows[13] = make_row(1, 0, SC_F1,    8'h00, 8'h00, 0, 7'b0000001);
		ctrl_rows[14] = make_row(1, 0, SC_F2,    8'h00, 8'h00, 0, 7'b0000000);
		ctrl_rows[15] = make_row(1, 1, SC_UP,    8'h00, 8'h00, 0, 7'b0000000);
		ctrl_rows[16] = make_row(0, 0, 8'h00,    8'h00, 8'h00, 1, 7'b0100000);
		ctrl_rows[17] = make_row(1, 1, SC_DOWN,  8'h00, 8'h00, 1, 7'b1100000);
		ctrl_rows[18] = make_row(1, 0, SC_UP,    8'h00, 8'h00, 1, 7'b1000000);
		ctrl_rows[19] = make_row(1, 0, SC_DOWN,  8'h08, 8'h00, 1, 7'b0100000);
		ctrl_rows[20] = make_row(0, 0, 8'h00,    8'h00, 8'h04, 1, 7'b1000000);
		ctrl_rows[21] = make_row(0, 0, 8'h00,    8'h02, 8'h01, 0, 7'b1100000);
		ctrl_rows[22] = make_row(0, 0, 8'h00,    8'h10, 8'h20, 0, 7'b0011000);
		ctrl_rows[23] = make_row(0, 0, 8'h00,    8'hC4, 8'h00, 0, 7'b0000000);
	endtask

	// ============================================================
	// watchdog
	// ============================================================
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_sys);
		stop_with_failure($sformatf("run timed out after %0d cycles", TIMEOUT_CYCLES));
	end

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		int         waited;
		logic [7:0] b;
		int         a;

		dl         = '0;
		key        = '0;
		joy0       = '0;
		joy1       = '0;
		rotate     = 1'b0;
		soft_reset = 1'b0;
		rd_addr    = '0;
		load_ctrl_table();

		wait (arst_n === 1'b1);
		next_cycle();
		check_value("ctrl", ctrl, 0);
		check_value("rom_loaded", rom_loaded, 0);
		check_value("core_reset", core_reset, 1);

		// download both banks in one stream
		dl.active = 1'b1;
		for (int i = 0; i < ROM_BYTES; i++) begin
			take_random_byte(b);
			rom_image[i] = b;
			send_byte(DL_ADDR_W'(i), b);
		end
		// inverted data so a wrongly routed write would show up
		for (int s = 0; s < N_STRAY; s++)
			send_byte(stray_addr[s], ~rom_image[stray_addr[s][BANK_AW:0]]);
		dl.active = 1'b0;

		waited = 0;
		while (!(rom_loaded === 1'b1 && core_reset === 1'b0) && waited < 4) begin
			next_cycle();
			waited++;
		end
		if (rom_loaded !== 1'b1 || core_reset !== 1'b0)
			stop_with_failure("core reset was not released within 4 cycles of download end");

		soft_reset = 1'b1;
		next_cycle();
		check_value("core_reset", core_reset, 1);
		soft_reset = 1'b0;
		next_cycle();
		check_value("core_reset", core_reset, 0);

		for (int i = 0; i < BANK_BYTES; i++)
			read_and_check(i);
		for (int s = 0; s < N_STRAY; s++) begin
			a = int'(stray_addr[s][BANK_AW:0]);
			read_and_check(a);
		end

		for (int r = 0; r < N_CTRL_ROWS; r++) begin
			key    = ctrl_rows[r].key_ev;
			joy0   = ctrl_rows[r].joy0;
			joy1   = ctrl_rows[r].joy1;
			rotate = ctrl_rows[r].rotate;
			next_cycle();
			key.strobe = 1'b0;
			next_cycle();
			next_cycle();
			check_value($sformatf("ctrl row %0d", r), ctrl, ctrl_rows[r].expected);
			// coin together with start1 is the service reset chord
			check_value($sformatf("core_reset row %0d", r), core_reset,
				ctrl_rows[r].expected.coin & ctrl_rows[r].expected.start1);
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== build.f ====
hdl/board_pkg.sv
hdl/ctrl_pkg.sv
hdl/rom_download_router.sv
hdl/rom_bank.sv
hdl/key_decoder.sv
hdl/control_mapper.sv
hdl/core_reset_gen.sv
hdl/arcade_io_shell.sv
verif/tb_clock_gen.sv
verif/tb_arcade_io_shell.sv
